// File: hdl/div_consts.svh
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand and result width
`define DIV_XLEN 32

// Destination register address width
`define DIV_ADDR_W 5

// Iteration counter width
// Also holds a leading-zero count of 0 to 32
`define DIV_CNT_W 6

`endif

// File: hdl/div_pkg.sv
`include "div_consts.svh"

package div_pkg;

    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,  // Signed quotient
        OP_DIVU = 2'd1,  // Unsigned quotient
        OP_REM  = 2'd2,  // Signed remainder
        OP_REMU = 2'd3   // Unsigned remainder
    } div_op_e;

    typedef struct packed {
        div_op_e                 op;
        logic [`DIV_XLEN-1:0]    dividend;
        logic [`DIV_XLEN-1:0]    divisor;
        logic [`DIV_ADDR_W-1:0]  rd;
    } div_req_t;

    typedef struct packed {
        logic [`DIV_XLEN-1:0]    dividend_mag;
        logic [`DIV_XLEN-1:0]    divisor_mag;
        logic                    quot_neg;      // Negate quotient at the end
        logic                    rem_neg;       // Negate remainder at the end
        logic                    want_rem;
        logic                    early;         // No iterations needed
        logic [`DIV_XLEN-1:0]    early_result;
        logic [`DIV_CNT_W-2:0]   shift;         // Divisor alignment
    } div_norm_t;

    typedef struct packed {
        logic [`DIV_XLEN-1:0]    result;
        logic [`DIV_ADDR_W-1:0]  rd;
    } div_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RUN    = 2'd1,
        ST_FINISH = 2'd2
    } div_state_e;

endpackage

// File: hdl/div_operand_prep.sv
`timescale 1ns/1ps
`include "div_consts.svh"

module div_operand_prep
    import div_pkg::*;
(
    input  div_req_t  req,
    output div_norm_t norm
);

    logic                   signed_op;
    logic                   dividend_neg;
    logic                   divisor_neg;
    logic                   div_zero;
    logic                   want_rem;
    logic [`DIV_XLEN-1:0]   dividend_mag;
    logic [`DIV_XLEN-1:0]   divisor_mag;
    logic [`DIV_CNT_W-1:0]  lz_dividend;
    logic [`DIV_CNT_W-1:0]  lz_divisor;
    logic [`DIV_CNT_W-1:0]  lz_diff;

    // Zero input gives the full width
    function automatic logic [`DIV_CNT_W-1:0] count_lz(input logic [`DIV_XLEN-1:0] v);
        logic [`DIV_CNT_W-1:0] n;
        logic                  found;
        n = `DIV_CNT_W'(`DIV_XLEN);
        found = 1'b0;
        for (int i = `DIV_XLEN - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                n = `DIV_CNT_W'(`DIV_XLEN - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign signed_op    = (req.op == OP_DIV) || (req.op == OP_REM);
    assign want_rem     = (req.op == OP_REM) || (req.op == OP_REMU);
    assign dividend_neg = signed_op && req.dividend[`DIV_XLEN-1];
    assign divisor_neg  = signed_op && req.divisor[`DIV_XLEN-1];
    assign div_zero     = (req.divisor == '0);

    // Most negative value maps onto itself, which is the right magnitude
    assign dividend_mag = dividend_neg ? -req.dividend : req.dividend;
    assign divisor_mag  = divisor_neg ? -req.divisor : req.divisor;

    assign lz_dividend  = count_lz(dividend_mag);
    assign lz_divisor   = count_lz(divisor_mag);
    assign lz_diff      = lz_divisor - lz_dividend;

    always_comb begin
        norm.dividend_mag = dividend_mag;
        norm.divisor_mag  = divisor_mag;
        norm.quot_neg     = (dividend_neg ^ divisor_neg) && !div_zero;
        norm.rem_neg      = dividend_neg;  // Remainder takes dividend sign
        norm.want_rem     = want_rem;
        norm.shift        = lz_diff[`DIV_CNT_W-2:0];

        if (div_zero) begin
            norm.early        = 1'b1;
            norm.early_result = want_rem ? req.dividend : '1;
        end else if (lz_dividend > lz_divisor) begin
            // Quotient is zero, remainder is the dividend itself
            norm.early        = 1'b1;
            norm.early_result = want_rem ? req.dividend : '0;
        end else begin
            norm.early        = 1'b0;
            norm.early_result = '0;
        end
    end

endmodule

// File: hdl/div_iter_core.sv
`timescale 1ns/1ps
`include "div_consts.svh"

module div_iter_core
    import div_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  div_norm_t              norm,
    input  logic [`DIV_ADDR_W-1:0] rd,
    output logic                   rsp_valid,
    output div_rsp_t               rsp,
    output logic                   busy
);

    div_state_e             state;
    logic [`DIV_CNT_W-1:0]  cnt;
    logic                   early_q;    // Early-out accepted last edge

    logic [`DIV_XLEN-1:0]   part_rem;   // Partial remainder
    logic [`DIV_XLEN-1:0]   div_al;     // Aligned divisor
    logic [`DIV_XLEN-1:0]   quot;
    logic                   quot_neg_q;
    logic                   rem_neg_q;
    logic                   want_rem_q;
    logic [`DIV_ADDR_W-1:0] rd_q;
    logic [`DIV_XLEN-1:0]   early_res_q;

    logic                   accept;
    logic                   rem_ge;
    logic [`DIV_XLEN-1:0]   rem_sub;
    logic [`DIV_XLEN-1:0]   quot_fix;
    logic [`DIV_XLEN-1:0]   rem_fix;
    logic [`DIV_XLEN-1:0]   final_result;

    assign accept  = req_valid && (state == ST_IDLE);
    assign busy    = (state != ST_IDLE);

    assign rem_ge  = (part_rem >= div_al);
    assign rem_sub = part_rem - div_al;

    assign quot_fix     = quot_neg_q ? -quot : quot;
    assign rem_fix      = rem_neg_q ? -part_rem : part_rem;
    assign final_result = want_rem_q ? rem_fix : quot_fix;

    // Control path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            early_q   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= early_q;  // Early-out answers one cycle after acceptance
            early_q   <= 1'b0;
            unique case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        if (norm.early) begin
                            early_q <= 1'b1;
                        end else begin
                            state <= ST_RUN;
                            cnt   <= {1'b0, norm.shift};
                        end
                    end
                end
                ST_RUN: begin
                    // shift+1 iterations in total
                    if (cnt == '0) begin
                        state <= ST_FINISH;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_FINISH: begin
                    rsp_valid <= 1'b1;
                    state     <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            part_rem    <= norm.dividend_mag;
            div_al      <= norm.divisor_mag << norm.shift;  // Leading ones line up
            quot        <= '0;
            quot_neg_q  <= norm.quot_neg;
            rem_neg_q   <= norm.rem_neg;
            want_rem_q  <= norm.want_rem;
            rd_q        <= rd;
            early_res_q <= norm.early_result;
        end else if (state == ST_RUN) begin
            if (rem_ge) begin
                part_rem <= rem_sub;
                quot     <= {quot[`DIV_XLEN-2:0], 1'b1};
            end else begin
                quot     <= {quot[`DIV_XLEN-2:0], 1'b0};
            end
            div_al <= div_al >> 1;
        end else if (state == ST_FINISH) begin
            rsp.result <= final_result;
            rsp.rd     <= rd_q;
        end
        if (early_q) begin
            rsp.result <= early_res_q;
            rsp.rd     <= rd_q;
        end
    end

    // Pipeline must stall while busy
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> !busy
    );

    // A second strobe cycle only for a fresh early-out request
    a_rsp_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |=> (!rsp_valid || $past(req_valid, 2))
    );

    a_busy_rsp_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(busy && rsp_valid)
    );

endmodule

// File: hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit
    import div_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  div_req_t  req,
    output logic      rsp_valid,
    output div_rsp_t  rsp,
    output logic      busy
);

    div_norm_t norm;  // Same-cycle prepared operands

    div_operand_prep div_operand_prep_inst (
        .req  (req),
        .norm (norm)
    );

    div_iter_core div_iter_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .norm      (norm),
        .rd        (req.rd),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy)
    );

endmodule

// File: testbench/div_unit_tb.sv
`timescale 1ns/1ps
`include "div_consts.svh"

module div_unit_tb
    import div_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int MAX_CYCLES   = 12000;  // ~240 requests at 35 cycles, plus margin
    localparam int RANDOM_COUNT = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    div_req_t               req;
    logic                   rsp_valid;
    div_rsp_t               rsp;
    logic                   busy;

    integer                 seed;
    int                     error_count;
    int                     check_count;
    int                     cycle_count = 0;
    logic [`DIV_ADDR_W-1:0] next_rd;

    div_unit div_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the divider stopped responding", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Scans upward so the highest set bit wins
    function automatic int leading_zeros(input logic [31:0] v);
        int n;
        n = 32;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) n = 31 - i;
        end
        return n;
    endfunction

    function automatic logic [31:0] magnitude(input logic [31:0] v, input logic is_signed);
        if (is_signed && v[31]) return ~v + 32'd1;
        return v;
    endfunction

    function automatic logic [31:0] expected_result(input div_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            OP_DIVU: return (b == '0) ? 32'hffff_ffff : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            OP_DIV: begin
                if (b == '0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h8000_0000;
                return sa / sb;
            end
            default: begin
                if (b == '0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                return sa % sb;
            end
        endcase
    endfunction

    // One cycle for early-out, shift+2 otherwise
    function automatic int expected_latency(input div_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic sgn;
        int   lz_a;
        int   lz_b;
        sgn = (op == OP_DIV) || (op == OP_REM);
        if (b == '0) return 1;
        lz_a = leading_zeros(magnitude(a, sgn));
        lz_b = leading_zeros(magnitude(b, sgn));
        if (lz_a > lz_b) return 1;
        return lz_b - lz_a + 2;
    endfunction

    task automatic do_request(input string name, input div_op_e op,
                              input logic [31:0] a, input logic [31:0] b);
        div_req_t r;
        logic     exp_busy;
        int       exp_latency;
        int       latency;
        int       busy_errors;
        r.op        = op;
        r.dividend  = a;
        r.divisor   = b;
        r.rd        = next_rd;
        exp_latency = expected_latency(op, a, b);
        exp_busy    = (exp_latency > 1);
        latency     = 0;
        busy_errors = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);  // Accepting edge
        req_valid <= 1'b0;
        @(negedge clk);
        if (busy !== exp_busy) busy_errors++;
        do begin
            @(negedge clk);
            latency++;
            if (rsp_valid !== 1'b1 && busy !== exp_busy) busy_errors++;
        end while (rsp_valid !== 1'b1);
        check_value({name, " result"}, expected_result(op, a, b), rsp.result);
        check_value({name, " rd"}, 32'(r.rd), 32'(rsp.rd));
        check_value({name, " latency"}, exp_latency, latency);
        check_value({name, " busy at response"}, 32'd0, 32'(busy));
        check_value({name, " busy mismatches"}, 32'd0, busy_errors);
        next_rd = next_rd + 5'd1;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
    endtask

    task automatic test_unsigned();
        do_request("divu small", OP_DIVU, 32'd100, 32'd7);
        do_request("remu small", OP_REMU, 32'd100, 32'd7);
        do_request("divu by one", OP_DIVU, 32'hffff_ffff, 32'd1);
        do_request("remu by one", OP_REMU, 32'hffff_ffff, 32'd1);
        do_request("divu equal", OP_DIVU, 32'hffff_ffff, 32'hffff_ffff);
        do_request("remu equal", OP_REMU, 32'h1234_5678, 32'h1234_5678);
        do_request("divu full width", OP_DIVU, 32'hffff_ffff, 32'd10);
        do_request("divu top bit", OP_DIVU, 32'h8000_0000, 32'd3);
        do_request("remu mixed", OP_REMU, 32'hdead_beef, 32'd1234);
    endtask

    task automatic test_signed();
        do_request("div pos pos", OP_DIV, 32'd100, 32'd7);
        do_request("div neg pos", OP_DIV, -32'd100, 32'd7);
        do_request("div pos neg", OP_DIV, 32'd100, -32'd7);
        do_request("div neg neg", OP_DIV, -32'd100, -32'd7);
        do_request("rem pos pos", OP_REM, 32'd100, 32'd7);
        do_request("rem neg pos", OP_REM, -32'd100, 32'd7);
        do_request("rem pos neg", OP_REM, 32'd100, -32'd7);
        do_request("rem neg neg", OP_REM, -32'd100, -32'd7);
        do_request("div overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        do_request("rem overflow", OP_REM, 32'h8000_0000, 32'hffff_ffff);
    endtask

    task automatic test_div_zero();
        do_request("div by zero", OP_DIV, 32'hffff_fff0, 32'd0);
        do_request("divu by zero", OP_DIVU, 32'h1234_5678, 32'd0);
        do_request("rem by zero", OP_REM, 32'hffff_fff0, 32'd0);
        do_request("remu by zero", OP_REMU, 32'h1234_5678, 32'd0);
    endtask

    task automatic test_early_out();
        do_request("divu short", OP_DIVU, 32'd5, 32'd100);
        do_request("remu short", OP_REMU, 32'd5, 32'd100);
        do_request("div short neg", OP_DIV, -32'd5, 32'd100);
        do_request("rem short neg", OP_REM, -32'd5, 32'd100);
        do_request("divu zero dividend", OP_DIVU, 32'd0, 32'd7);
        do_request("rem zero dividend", OP_REM, 32'd0, -32'd3);
    endtask

    // Short widths give early-outs and short runs
    function automatic logic [31:0] apply_width(input logic [31:0] v, input logic [1:0] sel);
        case (sel)
            2'd0:    return v & 32'h0000_00ff;
            2'd1:    return v & 32'h0000_ffff;
            2'd2:    return {{24{v[7]}}, v[7:0]};
            default: return v;
        endcase
    endfunction

    task automatic test_random();
        logic [31:0] raw;
        logic [31:0] a;
        logic [31:0] b;
        div_op_e     op;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            raw = $random(seed);
            op  = div_op_e'(raw[1:0]);
            a   = apply_width($random(seed), raw[3:2]);
            b   = apply_width($random(seed), raw[5:4]);
            do_request($sformatf("random %0d", i), op, a, b);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        seed        = 32'ha52c78ab;
        error_count = 0;
        check_count = 0;
        next_rd     = 5'd1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_unsigned();
        test_signed();
        test_div_zero();
        test_early_out();
        test_random();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: div_unit.f
+incdir+hdl
hdl/div_pkg.sv
hdl/div_operand_prep.sv
hdl/div_iter_core.sv
hdl/div_unit.sv
testbench/div_unit_tb.sv

// File: Makefile
# Verilator build and run for the divide unit

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= div_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
